// File: cpu16r.f
verilog/cpu16r_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/control_unit.sv
verilog/cpu16r_top.sv
testbench/cpu16r_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f cpu16r.f --top-module cpu16r_tb -o cpu16r_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cpu16r_sim > sim.log 2>&1 || true
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

// File: testbench/cpu16r_tb.sv
`default_nettype none

module cpu16r_tb
    import cpu16r_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] STACK_TOP = 32'h100;
    localparam logic [15:0] DATA_ADDR = 16'h00F0;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        start_i;
    logic        busy;
    logic        mem_rd;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    // program at 0x00..0xEF, data words at 0xF0..0xFF
    logic [31:0] prog [256];
    logic [31:0] dmem [16];
    logic [31:0] preload_word;

    // reference model of the ISA
    logic [31:0] model [16];
    logic [31:0] shadow [256];
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;

    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    int          exp_test [64];
    int          last_store [6];
    int          fails_in [6] = '{default: 0};
    int          n_stores = 0;
    int          pc_asm = 0;
    int          cur_test = 0;
    int          st_idx = 0;
    int          next_report = 1;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          cycle_limit;
    logic        quiet_chk = 1'b0;
    logic [31:0] want_addr;
    logic [31:0] want_data;
    int          want_test;

    opcode_e alu_ops [12] = '{OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_RSUBI, OP_AND,
                              OP_ANDI, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_ASHR};

    cpu16r_top #(
        .RESET_PC (32'h0),
        .RESET_SP (STACK_TOP)
    ) UUT (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .busy_o      (busy),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    always #20 clk = ~clk;

    assign mem_rdata = (mem_addr[7:4] == 4'hF) ? dmem[mem_addr[3:0]] : prog[mem_addr[7:0]];

    always @(posedge clk) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                dmem[i] <= 32'hDA7A_00F0 | 32'(i);
            end
            dmem[8] <= preload_word;
        end else if (mem_wr && mem_addr[7:4] == 4'hF) begin
            dmem[mem_addr[3:0]] <= mem_wdata;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            1:       return "alu ops";
            2:       return "conditions";
            3:       return "stack";
            4:       return "memory loads";
            5:       return "halt and restart";
            default: return "program";
        endcase
    endfunction

    function automatic logic is_imm(input opcode_e op);
        return op inside {OP_ADDI, OP_SUBI, OP_ANDI, OP_RSUBI};
    endfunction

    // flags follow from the operands of the last compare
    function automatic logic cond_expected(input cond_e c);
        case (c)
            EQ:      return cmp_a == cmp_b;
            NE:      return cmp_a != cmp_b;
            LTU:     return cmp_a < cmp_b;
            GTU:     return cmp_a > cmp_b;
            LEU:     return cmp_a <= cmp_b;
            GEU:     return cmp_a >= cmp_b;
            LTS:     return $signed(cmp_a) < $signed(cmp_b);
            GTS:     return $signed(cmp_a) > $signed(cmp_b);
            LES:     return $signed(cmp_a) <= $signed(cmp_b);
            GES:     return $signed(cmp_a) >= $signed(cmp_b);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [15:0] pair(input reg_e b, input reg_e c);
        return {b, c, 8'h00};
    endfunction

    function automatic logic [15:0] with_imm(input reg_e b, input logic [7:0] imm);
        return {b, 4'h0, imm};
    endfunction

    task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[n_stores] = addr;
        exp_data[n_stores] = data;
        exp_test[n_stores] = cur_test;
        last_store[cur_test] = n_stores;
        n_stores++;
        shadow[addr[7:0]] = data;
    endtask

    // places one instruction and advances the model by it
    task automatic emit(input opcode_e op, input cond_e c, input logic s, input reg_e ra,
                        input logic [15:0] low);
        reg_e        rb;
        reg_e        rc;
        logic [31:0] x;
        logic [31:0] y;
        rb = reg_e'(low[15:12]);
        rc = reg_e'(low[11:8]);
        prog[pc_asm] = {op, c, s, 1'b0, ra, low};
        pc_asm++;
        x = model[rb];
        y = is_imm(op) ? {24'h0, low[7:0]} : model[rc];
        if (cond_expected(c)) begin
            if (s) begin
                cmp_a = x;
                cmp_b = y;
            end
            case (op)
                OP_ADD, OP_ADDI: model[ra] = x + y;
                OP_SUB, OP_SUBI: model[ra] = x - y;
                OP_RSUBI:        model[ra] = y - x;
                OP_AND, OP_ANDI: model[ra] = x & y;
                OP_OR:           model[ra] = x | y;
                OP_XOR:          model[ra] = x ^ y;
                OP_SHL:          model[ra] = x << y[4:0];
                OP_SHR:          model[ra] = x >> y[4:0];
                OP_ASHR:         model[ra] = x[31] ? ~(~x >> y[4:0]) : x >> y[4:0];
                OP_LD:           model[ra] = shadow[low[7:0]];
                OP_LDR:          model[ra] = shadow[x[7:0]];
                OP_LDI:          model[ra] = {16'h0, low};
                OP_ST:           record_store({16'h0, low}, model[ra]);
                OP_STR:          record_store(x, model[ra]);
                OP_MOV:          model[ra] = x;
                OP_PUSH: begin
                    model[SP] = model[SP] - 32'd1;
                    record_store(model[SP], model[ra]);
                end
                OP_POP: begin
                    model[ra] = shadow[model[SP][7:0]];
                    model[SP] = model[SP] + 32'd1;
                end
                default: ;
            endcase
        end
    endtask

    // marker in R5 gets one bit per condition with NONE in the top bit
    task automatic sweep_conditions();
        emit(OP_SUB, NONE, 1'b1, R3, pair(R1, R2));
        emit(OP_LDI, NONE, 1'b0, R5, 16'h0);
        for (int c = 0; c < 11; c++) begin
            emit(OP_ADD, NONE, 1'b0, R5, pair(R5, R5));
            emit(OP_ADDI, NONE, 1'b0, R7, with_imm(R5, 8'd1));
            emit(OP_MOV, cond_e'(4'(c)), 1'b0, R5, pair(R7, R0));
        end
        emit(OP_ST, NONE, 1'b0, R5, DATA_ADDR);
    endtask

    task automatic flag_mismatch(input int t, input string what, input logic [31:0] want,
                                 input logic [31:0] got);
        $display("Mismatch in %s (%s): expected %h actual %h", test_name(t), what, want, got);
        fails_in[t]++;
    endtask

    task automatic log_failure(input int t, input string what);
        $display("Error in %s: %s", test_name(t), what);
        fails_in[t]++;
    endtask

    assign want_addr = exp_addr[st_idx[5:0]];
    assign want_data = exp_data[st_idx[5:0]];
    assign want_test = exp_test[st_idx[5:0]];

    a_store_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_wr |-> mem_addr == want_addr)
        else flag_mismatch($sampled(want_test), "store address", $sampled(want_addr),
                           $sampled(mem_addr));

    a_store_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_wr |-> mem_wdata == want_data)
        else flag_mismatch($sampled(want_test), "store data", $sampled(want_data),
                           $sampled(mem_wdata));

    a_store_count: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_wr |-> st_idx < n_stores)
        else log_failure(0, "the core stored more words than the program holds");

    a_halt_quiet: assert property (@(posedge clk) quiet_chk |-> !busy && !mem_rd && !mem_wr)
        else log_failure(5, "the core was busy or used memory while halted");

    always @(posedge clk) begin
        if (arst_n_i && mem_wr) begin
            st_idx <= st_idx + 1;
        end
    end

    // a test is done once its last store has gone by
    always @(negedge clk) begin
        if (next_report <= 5 && st_idx > last_store[next_report]) begin
            if (fails_in[next_report] == 0) begin
                $display("test %0d %s: pass", next_report, test_name(next_report));
                tests_passed <= tests_passed + 1;
            end else begin
                $display("test %0d %s: fail, %0d errors", next_report,
                         test_name(next_report), fails_in[next_report]);
                tests_failed <= tests_failed + 1;
            end
            next_report <= next_report + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        reg_e src;
        arst_n_i = 1'b0;
        start_i  = 1'b0;
        void'($urandom(32'hc6d87db7));
        for (int i = 0; i < 256; i++) begin
            prog[i]   = 32'hFC00_0000 | 32'(i);
            shadow[i] = 32'hDA7A_0000 | 32'(i);
        end
        for (int i = 0; i < 16; i++) begin
            model[i] = 32'h0;
        end
        model[SP] = STACK_TOP;
        cmp_a = 32'h0;
        cmp_b = 32'h0;
        preload_word = $urandom();
        shadow[8'hF8] = preload_word;

        cur_test = 1;
        emit(OP_LDI, NONE, 1'b0, R1, 16'($urandom()));
        emit(OP_LDI, NONE, 1'b0, R2, 16'($urandom()));
        emit(OP_SUB, NONE, 1'b0, R4, pair(R0, R1));
        foreach (alu_ops[i]) begin
            if (is_imm(alu_ops[i])) begin
                emit(alu_ops[i], NONE, 1'b0, R3, with_imm(R1, 8'($urandom())));
            end else begin
                src = (alu_ops[i] == OP_ASHR) ? R4 : R1;
                emit(alu_ops[i], NONE, 1'b0, R3, pair(src, R2));
            end
            emit(OP_ST, NONE, 1'b0, R3, DATA_ADDR);
        end

        cur_test = 2;
        emit(OP_LDI, NONE, 1'b0, R1, 16'h1234);
        emit(OP_LDI, NONE, 1'b0, R2, 16'h1234);
        sweep_conditions();
        emit(OP_LDI, NONE, 1'b0, R1, 16'd3);
        emit(OP_LDI, NONE, 1'b0, R2, 16'd2);
        emit(OP_SUB, NONE, 1'b0, R2, pair(R0, R2));
        sweep_conditions();
        // 0x80000000 minus one overflows
        emit(OP_LDI, NONE, 1'b0, R1, 16'd1);
        emit(OP_LDI, NONE, 1'b0, R4, 16'd31);
        emit(OP_SHL, NONE, 1'b0, R1, pair(R1, R4));
        emit(OP_LDI, NONE, 1'b0, R2, 16'd1);
        sweep_conditions();

        cur_test = 3;
        emit(OP_LDI, NONE, 1'b0, R8, 16'($urandom()));
        emit(OP_LDI, NONE, 1'b0, R9, 16'($urandom()));
        emit(OP_PUSH, NONE, 1'b0, R8, 16'h0);
        emit(OP_PUSH, NONE, 1'b0, R9, 16'h0);
        emit(OP_POP, NONE, 1'b0, R10, 16'h0);
        emit(OP_POP, NONE, 1'b0, R11, 16'h0);
        emit(OP_ST, NONE, 1'b0, R10, DATA_ADDR);
        emit(OP_ST, NONE, 1'b0, R11, DATA_ADDR);

        cur_test = 4;
        emit(OP_LD, NONE, 1'b0, R12, 16'h00F8);
        emit(OP_LDI, NONE, 1'b0, R13, 16'h00F8);
        emit(OP_LDR, NONE, 1'b0, R11, pair(R13, R0));
        emit(OP_LDI, NONE, 1'b0, R4, 16'h00F1);
        emit(OP_STR, NONE, 1'b0, R12, pair(R4, R0));
        emit(OP_STR, NONE, 1'b0, R11, pair(R4, R0));

        cur_test = 5;
        emit(OP_HALT, NONE, 1'b0, R0, 16'h0);
        emit(OP_ST, NONE, 1'b0, R8, DATA_ADDR);
        emit(OP_HALT, NONE, 1'b0, R0, 16'h0);
        cycle_limit = 2 * pc_asm + 50;

        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        wait (!busy);

        @(posedge clk);
        quiet_chk <= 1'b1;
        repeat (10) @(posedge clk);
        quiet_chk <= 1'b0;
        start_i   <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        wait (!busy);
        repeat (2) @(negedge clk);

        if (next_report != 6) begin
            $display("Error: only %0d of %0d expected stores were seen", st_idx, n_stores);
            fails_in[0]++;
        end
        $display("tests passed %0d, failed %0d, other errors %0d",
                 tests_passed, tests_failed, fails_in[0]);
        if (tests_failed == 0 && fails_in[0] == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none

module alu
    import cpu16r_pkg::*;
(
    input  wire alu_op_e     op_i,
    input  wire logic [31:0] a_i,
    input  wire logic [31:0] b_i,
    input  wire status_t     status_i,
    output logic [31:0]      result_o,
    output status_t          status_o
);

    logic [32:0] sum;
    logic [32:0] diff;
    logic [4:0]  shamt;

    assign sum   = {1'b0, a_i} + {1'b0, b_i};
    // carry out of a + ~b + 1 is set when there is no borrow
    assign diff  = {1'b0, a_i} + {1'b0, ~b_i} + 33'd1;
    assign shamt = b_i[4:0];

    always_comb begin
        status_o = status_i;
        case (op_i)
            ALU_ADD: begin
                result_o          = sum[31:0];
                status_o.carry    = sum[32];
                status_o.overflow = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
            end
            ALU_SUB: begin
                result_o          = diff[31:0];
                status_o.carry    = diff[32];
                status_o.overflow = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
            end
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SHL:  result_o = a_i << shamt;
            ALU_SHR:  result_o = a_i >> shamt;
            ALU_ASHR: result_o = $unsigned($signed(a_i) >>> shamt);
            default:  result_o = a_i;
        endcase
        status_o.zero     = (result_o == 32'd0);
        status_o.negative = result_o[31];
    end

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`default_nettype none

module control_unit
    import cpu16r_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n_i,
    input  wire         start_i,
    input  wire instr_t fetch_word_i,
    input  wire instr_t ir_i,
    input  wire status_t status_i,
    output ctrl_t       ctrl_o,
    output logic        busy_o
);

    typedef enum logic [3:0] {
        STOP, FETCH, ALU_RRR, ALU_RRI, ALU_RIR,
        LD, LDR, LDI, ST, STR, PUSH, POP, MOV
    } state_e;

    state_e state_q;
    state_e state_d;

    function automatic logic cond_holds(input cond_e c, input status_t s);
        case (c)
            EQ:      return s.zero;
            NE:      return !s.zero;
            LTU:     return !s.carry;
            GTU:     return s.carry && !s.zero;
            LEU:     return !s.carry || s.zero;
            GEU:     return s.carry;
            LTS:     return s.negative != s.overflow;
            GTS:     return !s.zero && (s.negative == s.overflow);
            LES:     return s.zero || (s.negative != s.overflow);
            GES:     return s.negative == s.overflow;
            default: return 1'b1;
        endcase
    endfunction

    function automatic alu_op_e alu_op_of(input opcode_e op);
        case (op)
            OP_ADD, OP_ADDI:           return ALU_ADD;
            OP_SUB, OP_SUBI, OP_RSUBI: return ALU_SUB;
            OP_AND, OP_ANDI:           return ALU_AND;
            OP_OR:                     return ALU_OR;
            OP_XOR:                    return ALU_XOR;
            OP_SHL:                    return ALU_SHL;
            OP_SHR:                    return ALU_SHR;
            OP_ASHR:                   return ALU_ASHR;
            default:                   return ALU_PASSA;
        endcase
    endfunction

    // common write-back of every ALU class
    task automatic alu_result(inout ctrl_t c, input instr_t ir);
        c.alu_op    = alu_op_of(ir.opcode);
        c.sel_in    = ir.reg_a;
        c.ld_reg    = 1'b1;
        c.ld_status = ir.set_status;
    endtask

    // reg_a <- reg_b op reg_c
    task automatic alu_rrr(inout ctrl_t c, input instr_t ir);
        c.sel_a    = ir.reg_b;
        c.oe_a_reg = 1'b1;
        c.sel_b    = ir.reg_c;
        c.oe_b_reg = 1'b1;
        alu_result(c, ir);
    endtask

    // reg_a <- reg_b op imm8
    task automatic alu_rri(inout ctrl_t c, input instr_t ir);
        c.sel_a      = ir.reg_b;
        c.oe_a_reg   = 1'b1;
        c.oe_b_ir    = 1'b1;
        c.b_mask_sel = MASK_IMM8;
        alu_result(c, ir);
    endtask

    // reg_a <- imm8 op reg_b
    task automatic alu_rir(inout ctrl_t c, input instr_t ir);
        c.oe_a_ir    = 1'b1;
        c.a_mask_sel = MASK_IMM8;
        c.sel_b      = ir.reg_b;
        c.oe_b_reg   = 1'b1;
        alu_result(c, ir);
    endtask

    // the word being fetched is decoded while it is loaded into the IR
    always_comb begin
        state_d = state_q;
        case (state_q)
            STOP: begin
                if (start_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (cond_holds(fetch_word_i.cond, status_i)) begin
                    case (fetch_word_i.opcode)
                        OP_HALT: state_d = STOP;
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                        OP_SHL, OP_SHR, OP_ASHR:   state_d = ALU_RRR;
                        OP_ADDI, OP_SUBI, OP_ANDI: state_d = ALU_RRI;
                        OP_RSUBI: state_d = ALU_RIR;
                        OP_LD:    state_d = LD;
                        OP_LDR:   state_d = LDR;
                        OP_LDI:   state_d = LDI;
                        OP_ST:    state_d = ST;
                        OP_STR:   state_d = STR;
                        OP_PUSH:  state_d = PUSH;
                        OP_POP:   state_d = POP;
                        OP_MOV:   state_d = MOV;
                        default:  state_d = FETCH;
                    endcase
                end
            end
            default: state_d = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= STOP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        ctrl_o = '0;
        case (state_q)
            // ir <- *(pc++)
            FETCH: begin
                ctrl_o.sel_b        = PC;
                ctrl_o.oe_b_reg     = 1'b1;
                ctrl_o.mem_rd       = 1'b1;
                ctrl_o.ld_ir        = 1'b1;
                ctrl_o.count_b      = 8'sd1;
                ctrl_o.post_count_b = 1'b1;
            end
            ALU_RRR: alu_rrr(ctrl_o, ir_i);
            ALU_RRI: alu_rri(ctrl_o, ir_i);
            ALU_RIR: alu_rir(ctrl_o, ir_i);
            LD: begin
                ctrl_o.oe_b_ir    = 1'b1;
                ctrl_o.b_mask_sel = MASK_IMM16;
                ctrl_o.mem_rd     = 1'b1;
                ctrl_o.sel_in     = ir_i.reg_a;
                ctrl_o.ld_reg     = 1'b1;
            end
            LDR: begin
                ctrl_o.sel_b    = ir_i.reg_b;
                ctrl_o.oe_b_reg = 1'b1;
                ctrl_o.mem_rd   = 1'b1;
                ctrl_o.sel_in   = ir_i.reg_a;
                ctrl_o.ld_reg   = 1'b1;
            end
            LDI: begin
                ctrl_o.oe_a_ir    = 1'b1;
                ctrl_o.a_mask_sel = MASK_IMM16;
                ctrl_o.alu_op     = ALU_PASSA;
                ctrl_o.sel_in     = ir_i.reg_a;
                ctrl_o.ld_reg     = 1'b1;
            end
            ST: begin
                ctrl_o.sel_a      = ir_i.reg_a;
                ctrl_o.oe_a_reg   = 1'b1;
                ctrl_o.oe_b_ir    = 1'b1;
                ctrl_o.b_mask_sel = MASK_IMM16;
                ctrl_o.mem_wr     = 1'b1;
            end
            STR: begin
                ctrl_o.sel_a    = ir_i.reg_a;
                ctrl_o.oe_a_reg = 1'b1;
                ctrl_o.sel_b    = ir_i.reg_b;
                ctrl_o.oe_b_reg = 1'b1;
                ctrl_o.mem_wr   = 1'b1;
            end
            // *(--sp) <- reg_a
            PUSH: begin
                ctrl_o.sel_a       = ir_i.reg_a;
                ctrl_o.oe_a_reg    = 1'b1;
                ctrl_o.sel_b       = SP;
                ctrl_o.oe_b_reg    = 1'b1;
                ctrl_o.count_b     = -8'sd1;
                ctrl_o.pre_count_b = 1'b1;
                ctrl_o.mem_wr      = 1'b1;
            end
            // reg_a <- *(sp++)
            POP: begin
                ctrl_o.sel_b        = SP;
                ctrl_o.oe_b_reg     = 1'b1;
                ctrl_o.count_b      = 8'sd1;
                ctrl_o.post_count_b = 1'b1;
                ctrl_o.mem_rd       = 1'b1;
                ctrl_o.sel_in       = ir_i.reg_a;
                ctrl_o.ld_reg       = 1'b1;
            end
            MOV: begin
                ctrl_o.sel_a    = ir_i.reg_b;
                ctrl_o.oe_a_reg = 1'b1;
                ctrl_o.alu_op   = ALU_PASSA;
                ctrl_o.sel_in   = ir_i.reg_a;
                ctrl_o.ld_reg   = 1'b1;
            end
            default: ;
        endcase
    end

    assign busy_o = (state_q != STOP);

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ctrl_o.mem_rd && ctrl_o.mem_wr));

endmodule

`default_nettype wire

// File: verilog/cpu16r_pkg.sv
`default_nettype none

package cpu16r_pkg;

    // LDR loads a word through a register
    typedef enum logic [5:0] {
        OP_NOP,
        OP_HALT,
        OP_ADD,
        OP_ADDI,
        OP_SUB,
        OP_SUBI,
        OP_RSUBI,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_XOR,
        OP_SHL,
        OP_SHR,
        OP_ASHR,
        OP_LD,
        OP_LDI,
        OP_ST,
        OP_STR,
        OP_PUSH,
        OP_POP,
        OP_MOV,
        OP_LDR
    } opcode_e;

    // carry set means no borrow after a subtract
    typedef enum logic [3:0] {
        NONE, EQ, NE, LTU, GTU, LEU, GEU, LTS, GTS, LES, GES
    } cond_e;

    typedef enum logic [3:0] {
        R0, R1, R2, R3, R4, R5, R6, R7,
        R8, R9, R10, R11, R12, R13, SP, PC
    } reg_e;

    typedef enum logic [3:0] {
        ALU_PASSA, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SHL, ALU_SHR, ALU_ASHR
    } alu_op_e;

    typedef enum logic [1:0] {
        MASK_FULL, MASK_IMM8, MASK_IMM16
    } mask_e;

    // low 16 bits double as addr16
    typedef struct packed {
        opcode_e    opcode;
        cond_e      cond;
        logic       set_status;
        logic       spare;
        reg_e       reg_a;
        reg_e       reg_b;
        reg_e       reg_c;
        logic [7:0] imm8;
    } instr_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } status_t;

    typedef struct packed {
        logic              mem_rd;
        logic              mem_wr;
        reg_e              sel_a;
        reg_e              sel_b;
        reg_e              sel_in;
        logic              oe_a_reg;
        logic              oe_b_reg;
        logic              ld_reg;
        logic              oe_a_ir;
        logic              oe_b_ir;
        mask_e             a_mask_sel;
        mask_e             b_mask_sel;
        logic signed [7:0] count_b;
        logic              pre_count_b;
        logic              post_count_b;
        logic              ld_ir;
        logic              ld_status;
        alu_op_e           alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

// File: verilog/cpu16r_top.sv
`default_nettype none

module cpu16r_top
    import cpu16r_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0,
    parameter logic [31:0] RESET_SP = 32'h100
) (
    input  wire         clk,
    input  wire         arst_n_i,
    input  wire         start_i,
    output logic        busy_o,
    output logic        mem_rd_o,
    output logic        mem_wr_o,
    output logic [31:0] mem_addr_o,
    output logic [31:0] mem_wdata_o,
    input  wire [31:0]  mem_rdata_i
);

    ctrl_t       ctrl;
    instr_t      ir_q;
    status_t     status_q;
    status_t     next_status;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    logic [31:0] bus_a;
    logic [31:0] bus_b;
    logic [31:0] alu_result;
    logic [31:0] reg_wdata;

    function automatic logic [31:0] mask_word(input logic [31:0] w, input mask_e m);
        case (m)
            MASK_IMM8:  return {24'd0, w[7:0]};
            MASK_IMM16: return {16'd0, w[15:0]};
            default:    return w;
        endcase
    endfunction

    control_unit u_control_unit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .fetch_word_i (instr_t'(mem_rdata_i)),
        .ir_i         (ir_q),
        .status_i     (status_q),
        .ctrl_o       (ctrl),
        .busy_o       (busy_o)
    );

    reg_file #(
        .RESET_PC (RESET_PC),
        .RESET_SP (RESET_SP)
    ) u_reg_file (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .sel_a_i        (ctrl.sel_a),
        .sel_b_i        (ctrl.sel_b),
        .sel_in_i       (ctrl.sel_in),
        .ld_i           (ctrl.ld_reg),
        .wdata_i        (reg_wdata),
        .count_b_i      (ctrl.count_b),
        .pre_count_b_i  (ctrl.pre_count_b),
        .post_count_b_i (ctrl.post_count_b),
        .rdata_a_o      (rdata_a),
        .rdata_b_o      (rdata_b)
    );

    // register port has priority over the instruction word
    assign bus_a = ctrl.oe_a_reg ? rdata_a :
                   ctrl.oe_a_ir  ? mask_word(ir_q, ctrl.a_mask_sel) : 32'd0;
    assign bus_b = ctrl.oe_b_reg ? rdata_b :
                   ctrl.oe_b_ir  ? mask_word(ir_q, ctrl.b_mask_sel) : 32'd0;

    alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (bus_a),
        .b_i      (bus_b),
        .status_i (status_q),
        .result_o (alu_result),
        .status_o (next_status)
    );

    assign reg_wdata = ctrl.mem_rd ? mem_rdata_i : alu_result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ir_q     <= '0;
            status_q <= '0;
        end else begin
            if (ctrl.ld_ir) begin
                ir_q <= instr_t'(mem_rdata_i);
            end
            if (ctrl.ld_status) begin
                status_q <= next_status;
            end
        end
    end

    assign mem_rd_o    = ctrl.mem_rd;
    assign mem_wr_o    = ctrl.mem_wr;
    assign mem_addr_o  = bus_b;
    assign mem_wdata_o = bus_a;

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file
    import cpu16r_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0,
    parameter logic [31:0] RESET_SP = 32'h100
) (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire reg_e               sel_a_i,
    input  wire reg_e               sel_b_i,
    input  wire reg_e               sel_in_i,
    input  wire logic               ld_i,
    input  wire logic [31:0]        wdata_i,
    input  wire logic signed [7:0]  count_b_i,
    input  wire logic               pre_count_b_i,
    input  wire logic               post_count_b_i,
    output logic [31:0]             rdata_a_o,
    output logic [31:0]             rdata_b_o
);

    logic [31:0] regs [16];
    logic [31:0] count_ext;
    logic [31:0] counted_b;

    assign count_ext = {{24{count_b_i[7]}}, count_b_i};
    assign counted_b = regs[sel_b_i] + count_ext;

    assign rdata_a_o = regs[sel_a_i];
    // pre-count shows the moved pointer on the same cycle
    assign rdata_b_o = pre_count_b_i ? counted_b : regs[sel_b_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
            regs[PC] <= RESET_PC;
            regs[SP] <= RESET_SP;
        end else begin
            if (pre_count_b_i || post_count_b_i) begin
                regs[sel_b_i] <= counted_b;
            end
            // write port comes last so it overrides the counter on the same register
            if (ld_i) begin
                regs[sel_in_i] <= wdata_i;
            end
        end
    end

    a_one_count_mode: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(pre_count_b_i && post_count_b_i));

endmodule

`default_nettype wire
